// File: Makefile
TOP = tb_uart_tx_bank

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/100ps --top-module $(TOP) -f tb.f

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps --top-module $(TOP) \
		-Mdir obj_dir -f tb.f
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	! grep -q "Simulation failed" sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: design/tx_dispatch.sv
module tx_dispatch #(
    parameter int NUM_LANES = 4
) (
    input  logic                    clk_i,
    input  logic                    arstn_i,
    input  logic                    req_i,
    input  uart_msg_pkg::tx_req_t   tx_req_i,
    output logic                    ack_o,
    output logic [NUM_LANES-1:0]    lane_req_o,
    output uart_cfg_pkg::byte_t     lane_data_o,
    input  logic [NUM_LANES-1:0]    lane_ack_i,
    input  logic [NUM_LANES-1:0]    pending_i
);

    typedef enum logic [1:0] {
        IDLE    = 2'b00,
        FORWARD = 2'b01,
        HOLD    = 2'b10,
        RELEASE = 2'b11
    } disp_state_t;

    disp_state_t          state;
    logic [NUM_LANES-1:0] target; // one-hot lane of the running transfer
    logic [NUM_LANES-1:0] busy;   // lane took a byte whose frame is not reported yet
    logic [NUM_LANES-1:0] req_oh;
    logic                 chan_ok;
    logic                 lane_free;
    logic                 take;
    logic                 tgt_ack;

    assign chan_ok   = int'(tx_req_i.chan) < NUM_LANES;
    assign req_oh    = NUM_LANES'(1) << tx_req_i.chan; // zero for out-of-range chan
    assign lane_free = ~|(req_oh & (busy | pending_i));
    assign take      = (state == IDLE) && req_i && lane_free;
    assign tgt_ack   = |(target & lane_ack_i);

    assign lane_req_o = ((state == FORWARD) || (state == HOLD)) ? target : '0;
    assign ack_o      = ((state == FORWARD) && tgt_ack) || (state == HOLD) || (state == RELEASE);

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            state  <= IDLE;
            target <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (take) begin
                        target <= req_oh;
                        state  <= chan_ok ? FORWARD : HOLD; // bad chan is acked and dropped
                    end
                end
                FORWARD: begin
                    if (tgt_ack) state <= HOLD;
                end
                HOLD: begin
                    if (!req_i) state <= RELEASE;
                end
                RELEASE: begin
                    if (!tgt_ack) state <= IDLE; // lane side back to zero
                end
                default: state <= IDLE;
            endcase
        end
    end

    // a lane stays busy until the collector has picked up its frame end
    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            busy <= '0;
        end else begin
            busy <= (busy & ~pending_i) | (((state == FORWARD) && tgt_ack) ? target : '0);
        end
    end

    always_ff @(posedge clk_i) begin
        if (take) lane_data_o <= tx_req_i.data;
    end

    a_one_lane_req: assert property (
        @(posedge clk_i) disable iff (!arstn_i) $onehot0(lane_req_o)
    );

endmodule

// File: design/tx_done_collector.sv
module tx_done_collector #(
    parameter int NUM_LANES = 4
) (
    input  logic                   clk_i,
    input  logic                   arstn_i,
    input  logic [NUM_LANES-1:0]   frame_done_i,
    output logic [NUM_LANES-1:0]   pending_o,
    output logic                   done_req_o,
    output uart_msg_pkg::tx_done_t done_o,
    input  logic                   done_ack_i
);

    typedef enum logic [1:0] {
        IDLE     = 2'b00,
        REPORT   = 2'b01,
        WAIT_LOW = 2'b10
    } coll_state_t;

    coll_state_t          state;
    logic [NUM_LANES-1:0] pending_q;
    logic [NUM_LANES-1:0] cand;   // pending plus events arriving now
    logic [NUM_LANES-1:0] rot;    // cand rotated to start after cur
    logic [NUM_LANES-1:0] clr;
    uart_cfg_pkg::chan_t  cur;    // lane being reported and rr pointer
    uart_cfg_pkg::chan_t  next_pick;
    int                   offs;

    assign cand = pending_q | frame_done_i;
    assign clr  = ((state == REPORT) && done_ack_i) ? (NUM_LANES'(1) << cur) : '0;

    // lowest set bit of the rotated vector wins
    always_comb begin
        rot  = NUM_LANES'({cand, cand} >> ({1'b0, cur} + 5'd1));
        offs = 0;
        for (int i = NUM_LANES - 1; i >= 0; i--) begin
            if (rot[i]) offs = i;
        end
        next_pick = uart_cfg_pkg::chan_t'((int'(cur) + 1 + offs) % NUM_LANES);
    end

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            pending_q <= '0;
        end else begin
            pending_q <= cand & ~clr;
        end
    end

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            state <= IDLE;
            cur   <= uart_cfg_pkg::chan_t'(NUM_LANES - 1); // first search starts at lane 0
        end else begin
            case (state)
                IDLE: begin
                    if (|cand) begin
                        cur   <= next_pick;
                        state <= REPORT;
                    end
                end
                REPORT: begin
                    if (done_ack_i) state <= WAIT_LOW;
                end
                WAIT_LOW: begin
                    if (!done_ack_i) state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign pending_o   = pending_q;
    assign done_req_o  = (state == REPORT);
    assign done_o.chan = cur;

    a_done_stable: assert property (
        @(posedge clk_i) disable iff (!arstn_i)
        (done_req_o && $past(done_req_o)) |-> $stable(done_o)
    );

endmodule

// File: design/uart_cfg_pkg.sv
package uart_cfg_pkg;

    // a frame is a start bit, DATA_BITS data bits LSB first and one stop bit
    localparam int DATA_BITS = 8;

    // largest bank size sets the width of a channel index
    localparam int MAX_LANES = 16;

    localparam int CHAN_W = $clog2(MAX_LANES); // 4 for 16 lanes

    typedef logic [DATA_BITS-1:0] byte_t; // one payload byte
    typedef logic [CHAN_W-1:0]    chan_t; // channel / lane index

endpackage

// File: design/uart_msg_pkg.sv
package uart_msg_pkg;

    // host request with chan in the upper bits
    typedef struct packed {
        uart_cfg_pkg::chan_t chan; // target lane
        uart_cfg_pkg::byte_t data; // byte to send
    } tx_req_t;

    // completion report back to the host
    typedef struct packed {
        uart_cfg_pkg::chan_t chan; // lane whose frame ended
    } tx_done_t;

endpackage

// File: design/uart_tx_bank.sv
module uart_tx_bank #(
    parameter int NUM_LANES = 4,
    parameter int CLK_FREQ  = 1_000_000,
    parameter int BAUD_RATE = 125_000
) (
    input  logic                   clk_i,
    input  logic                   arstn_i,
    input  logic                   req_i,
    input  uart_msg_pkg::tx_req_t  tx_req_i,
    output logic                   ack_o,
    output logic                   done_req_o,
    output uart_msg_pkg::tx_done_t done_o,
    input  logic                   done_ack_i,
    output logic [NUM_LANES-1:0]   uart_tx_o
);

    logic [NUM_LANES-1:0] lane_req;
    logic [NUM_LANES-1:0] lane_ack;
    logic [NUM_LANES-1:0] frame_done;
    logic [NUM_LANES-1:0] pending;
    uart_cfg_pkg::byte_t  lane_data; // shared by all lanes

    if ((NUM_LANES < 2) || (NUM_LANES > uart_cfg_pkg::MAX_LANES)) begin : g_bad_size
        $error("NUM_LANES out of range");
    end

    tx_dispatch #(
        .NUM_LANES (NUM_LANES)
    ) u_dispatch (
        .clk_i       (clk_i),
        .arstn_i     (arstn_i),
        .req_i       (req_i),
        .tx_req_i    (tx_req_i),
        .ack_o       (ack_o),
        .lane_req_o  (lane_req),
        .lane_data_o (lane_data),
        .lane_ack_i  (lane_ack),
        .pending_i   (pending)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        uart_tx_lane #(
            .CLK_FREQ  (CLK_FREQ),
            .BAUD_RATE (BAUD_RATE)
        ) u_lane (
            .clk_i        (clk_i),
            .arstn_i      (arstn_i),
            .req_i        (lane_req[i]),
            .data_i       (lane_data),
            .ack_o        (lane_ack[i]),
            .frame_done_o (frame_done[i]),
            .uart_tx_o    (uart_tx_o[i])
        );
    end

    tx_done_collector #(
        .NUM_LANES (NUM_LANES)
    ) u_collector (
        .clk_i        (clk_i),
        .arstn_i      (arstn_i),
        .frame_done_i (frame_done),
        .pending_o    (pending),
        .done_req_o   (done_req_o),
        .done_o       (done_o),
        .done_ack_i   (done_ack_i)
    );

endmodule

// File: design/uart_tx_lane.sv
module uart_tx_lane #(
    parameter int CLK_FREQ  = 1_000_000,
    parameter int BAUD_RATE = 125_000
) (
    input  logic                clk_i,
    input  logic                arstn_i,
    input  logic                req_i,
    input  uart_cfg_pkg::byte_t data_i,
    output logic                ack_o,
    output logic                frame_done_o,
    output logic                uart_tx_o
);

    localparam int DIVIDER = CLK_FREQ / BAUD_RATE; // clock cycles per bit
    localparam int BAUD_W  = (DIVIDER > 1) ? $clog2(DIVIDER) : 1;
    localparam int BIT_W   = $clog2(uart_cfg_pkg::DATA_BITS);

    localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(DIVIDER - 1);
    localparam logic [BIT_W-1:0]  BIT_LAST  = BIT_W'(uart_cfg_pkg::DATA_BITS - 1);

    typedef enum logic [2:0] {
        IDLE  = 3'b000,
        START = 3'b001,
        DATA  = 3'b010,
        STOP  = 3'b011,
        WAIT  = 3'b100
    } lane_state_t;

    lane_state_t         state;
    logic [BAUD_W-1:0]   baud_cnt;
    logic [BIT_W-1:0]    bit_cnt;
    uart_cfg_pkg::byte_t shift_q;
    logic                baud_done;
    logic                last_bit;
    logic                accept;
    logic                on_line; // start, data or stop bit in progress

    assign accept       = (state == IDLE) && req_i && !ack_o;
    assign baud_done    = (baud_cnt == BAUD_LAST);
    assign last_bit     = (bit_cnt == BIT_LAST);
    assign on_line      = (state == START) || (state == DATA) || (state == STOP);
    assign frame_done_o = (state == WAIT); // last cycle of the stop bit

    // registered line output trails the state by one cycle
    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            state     <= IDLE;
            uart_tx_o <= 1'b1;
        end else begin
            case (state)
                IDLE: begin
                    uart_tx_o <= 1'b1;
                    if (accept) state <= START;
                end
                START: begin
                    uart_tx_o <= 1'b0;
                    if (baud_done) state <= DATA;
                end
                DATA: begin
                    uart_tx_o <= shift_q[0];
                    if (baud_done && last_bit) state <= STOP;
                end
                STOP: begin
                    uart_tx_o <= 1'b1;
                    if (baud_done) state <= WAIT;
                end
                WAIT: begin
                    uart_tx_o <= 1'b1;
                    state     <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // ack held until the dispatcher lets go
    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            ack_o <= 1'b0;
        end else if (accept) begin
            ack_o <= 1'b1;
        end else if (!req_i) begin
            ack_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            baud_cnt <= '0;
        end else if (!on_line || baud_done) begin
            baud_cnt <= '0;
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            bit_cnt <= '0;
        end else if (state != DATA) begin
            bit_cnt <= '0;
        end else if (baud_done) begin
            bit_cnt <= last_bit ? '0 : bit_cnt + 1'b1;
        end
    end

    // LSB first
    always_ff @(posedge clk_i) begin
        if (accept) begin
            shift_q <= data_i;
        end else if ((state == DATA) && baud_done) begin
            shift_q <= shift_q >> 1;
        end
    end

    a_idle_line_high: assert property (
        @(posedge clk_i) disable iff (!arstn_i) (state == IDLE) |-> uart_tx_o
    );

    a_ack_from_idle: assert property (
        @(posedge clk_i) disable iff (!arstn_i) $rose(ack_o) |-> ($past(state) == IDLE)
    );

endmodule

// File: tb.f
design/uart_cfg_pkg.sv
design/uart_msg_pkg.sv
design/tx_dispatch.sv
design/uart_tx_lane.sv
design/tx_done_collector.sv
design/uart_tx_bank.sv
verif/uart_line_monitor.sv
verif/tb_uart_tx_bank.sv

// File: verif/tb_uart_tx_bank.sv
module tb_uart_tx_bank;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_LANES       = 4;
    localparam int CLK_FREQ        = 1_000_000;
    localparam int BAUD_RATE       = 125_000;
    localparam int DIVIDER         = CLK_FREQ / BAUD_RATE;
    localparam int NUM_BYTES       = 8; // chan 5 request included
    localparam int WATCHDOG_CYCLES = (NUM_BYTES + 4) * 80;

    logic                   clk;
    logic                   arstn;
    logic                   req;
    uart_msg_pkg::tx_req_t  tx_req;
    logic                   ack;
    logic                   done_req;
    uart_msg_pkg::tx_done_t done;
    logic                   done_ack;
    logic [NUM_LANES-1:0]   uart_tx;
    logic                   ack_q;
    int                     seed;
    int                     errors;
    int                     mon_err [NUM_LANES];
    logic [NUM_LANES-1:0]   mon_valid;
    uart_cfg_pkg::byte_t    mon_data [NUM_LANES];
    uart_cfg_pkg::byte_t    exp_q [NUM_LANES][$]; // bytes still to appear on each line
    int                     queued [NUM_LANES];
    int                     unreported [NUM_LANES]; // accepted but not reported yet
    int                     ended [NUM_LANES];      // seen on the line but not reported yet
    int                     frames;
    int                     reports;

    uart_tx_bank #(
        .NUM_LANES (NUM_LANES),
        .CLK_FREQ  (CLK_FREQ),
        .BAUD_RATE (BAUD_RATE)
    ) UUT (
        .clk_i      (clk),
        .arstn_i    (arstn),
        .req_i      (req),
        .tx_req_i   (tx_req),
        .ack_o      (ack),
        .done_req_o (done_req),
        .done_o     (done),
        .done_ack_i (done_ack),
        .uart_tx_o  (uart_tx)
    );

    for (genvar j = 0; j < NUM_LANES; j++) begin : g_line
        uart_line_monitor #(
            .DIVIDER (DIVIDER)
        ) u_mon (
            .clk_i    (clk),
            .arstn_i  (arstn),
            .line_i   (uart_tx[j]),
            .valid_o  (mon_valid[j]),
            .data_o   (mon_data[j]),
            .errors_o (mon_err[j])
        );

        a_quiet_line: assert property (@(posedge clk) disable iff (!arstn)
            (queued[j] == 0) |-> uart_tx[j])
        else begin
            errors++;
            $display("FAIL quiet_line_%0d expected 1 actual 0", j);
        end
    end

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    a_reset_values: assert property (@(posedge clk)
        $rose(arstn) |-> (&uart_tx && !ack && !done_req))
    else begin
        errors++;
        $display("FAIL reset_values expected 1111/0/0 actual %b/%b/%b", uart_tx, ack, done_req);
    end

    always @(posedge clk) begin : bookkeeping
        uart_cfg_pkg::byte_t want;
        int                  c;
        if (!arstn) begin
            ack_q <= 1'b0;
        end else begin
            c = int'(tx_req.chan);
            if (ack && !ack_q && (c < NUM_LANES)) begin
                a_held_off: assert (unreported[c] == 0) else begin
                    errors++;
                    $display("FAIL held_off ch %0d expected 0 actual %0d", c, unreported[c]);
                end
                exp_q[c].push_back(tx_req.data);
                queued[c]++;
                unreported[c]++;
                frames++;
            end
            for (int k = 0; k < NUM_LANES; k++) begin
                if (mon_valid[k]) begin
                    a_expected: assert (queued[k] > 0) else begin
                        errors++;
                        $display("frame on line %0d with no byte sent to it", k);
                    end
                    if (queued[k] > 0) begin
                        want = exp_q[k].pop_front();
                        queued[k]--;
                        ended[k]++;
                        a_line_data: assert (mon_data[k] == want) else begin
                            errors++;
                            $display("FAIL line_data ch %0d expected %h actual %h",
                                     k, want, mon_data[k]);
                        end
                    end
                end
            end
            if (done_req && done_ack) begin
                c = int'(done.chan);
                a_report: assert ((c < NUM_LANES) && (ended[c] > 0)) else begin
                    errors++;
                    $display("done report for channel %0d without a finished frame", c);
                end
                if ((c < NUM_LANES) && (ended[c] > 0)) begin
                    ended[c]--;
                    unreported[c]--;
                    reports++;
                end
            end
            ack_q <= ack;
        end
    end

    // host side of the done port
    initial begin
        done_ack = 1'b0;
        forever begin
            do @(posedge clk); while (done_req !== 1'b1);
            #1 done_ack = 1'b1;
            do @(posedge clk); while (done_req);
            #1 done_ack = 1'b0;
        end
    end

    task automatic send_byte(input int chan);
        @(posedge clk);
        #1;
        tx_req.chan = uart_cfg_pkg::chan_t'(chan);
        tx_req.data = uart_cfg_pkg::byte_t'($random(seed));
        req         = 1'b1;
        do @(posedge clk); while (!ack);
        #1 req = 1'b0;
        do @(posedge clk); while (ack);
    endtask

    task automatic wait_idle();
        do @(posedge clk); while ((frames != reports) || done_req);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, test did not finish", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    initial begin : main_seq
        int total;
        int mon_sum;
        seed   = 32'h7aaf_0cde;
        arstn  = 1'b0;
        req    = 1'b0;
        tx_req = '0;
        repeat (8) @(posedge clk);
        #1 arstn = 1'b1;
        repeat (2) @(posedge clk);

        send_byte(0);
        send_byte(1);
        send_byte(1); // waits for the first report on ch 1
        wait_idle();
        send_byte(5); // out of range
        repeat (12 * DIVIDER) @(posedge clk);
        send_byte(2);
        send_byte(3);
        send_byte(0);
        send_byte(1);
        wait_idle();
        repeat (4) @(posedge clk);

        total   = 0;
        mon_sum = 0;
        for (int k = 0; k < NUM_LANES; k++) begin
            a_all_seen: assert ((queued[k] == 0) && (unreported[k] == 0)) else begin
                total++;
                $display("channel %0d left %0d bytes unseen, %0d unreported",
                         k, queued[k], unreported[k]);
            end
            mon_sum += mon_err[k];
        end
        a_frame_count: assert (frames == NUM_BYTES - 1) else begin
            total++;
            $display("FAIL frame_count expected %0d actual %0d", NUM_BYTES - 1, frames);
        end
        total += errors;
        $display("closing report: %0d checker errors, %0d monitor errors", total, mon_sum);
        if ((total + mon_sum) == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: verif/uart_line_monitor.sv
module uart_line_monitor #(
    parameter int DIVIDER = 8
) (
    input  logic                clk_i,
    input  logic                arstn_i,
    input  logic                line_i,
    output logic                valid_o,
    output uart_cfg_pkg::byte_t data_o,
    output int                  errors_o
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF    = DIVIDER / 2;
    localparam int STOP_AT = (uart_cfg_pkg::DATA_BITS + 1) * DIVIDER + HALF; // stop bit middle

    logic                busy;
    logic                line_q;
    int                  cnt; // cycles since the start bit was first seen
    uart_cfg_pkg::byte_t shreg;

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            busy    <= 1'b0;
            line_q  <= 1'b1;
            cnt     <= 0;
            valid_o <= 1'b0;
            shreg   <= '0;
            data_o  <= '0;
        end else begin
            valid_o <= 1'b0;
            line_q  <= line_i;
            if (!busy) begin
                if (!line_i) begin
                    busy <= 1'b1;
                    cnt  <= 1;
                end
            end else begin
                cnt <= cnt + 1;
                if (cnt == STOP_AT) begin
                    busy    <= 1'b0;
                    valid_o <= 1'b1;
                    data_o  <= shreg;
                end else if (((cnt % DIVIDER) == HALF) && (cnt > DIVIDER)) begin
                    shreg <= {line_i, shreg[uart_cfg_pkg::DATA_BITS-1:1]}; // LSB arrives first
                end
            end
        end
    end

    a_start_low: assert property (@(posedge clk_i) disable iff (!arstn_i)
        (busy && (cnt == HALF)) |-> !line_i)
    else begin
        errors_o++;
        $display("FAIL start_bit %m expected 0 actual 1");
    end

    a_stop_high: assert property (@(posedge clk_i) disable iff (!arstn_i)
        (busy && (cnt == STOP_AT)) |-> line_i)
    else begin
        errors_o++;
        $display("FAIL stop_bit %m expected 1 actual 0");
    end

    // edges only on bit boundaries
    a_bit_length: assert property (@(posedge clk_i) disable iff (!arstn_i)
        (busy && (line_i != line_q)) |-> ((cnt % DIVIDER) == 0))
    else begin
        errors_o++;
        $display("%m: line changed in the middle of a bit");
    end

endmodule
